/* src/busPkg.sv */
package busPkg;

  // Memory geometry
  localparam int DATA_W  = 64;
  localparam int ADDR_W  = 16;               // Byte address
  localparam int LANES   = DATA_W / 8;
  localparam int LANE_W  = $clog2(LANES);    // Byte offset bits inside a word
  localparam int WORD_AW = ADDR_W - LANE_W;  // Word address bits

  // Single-beat access sizes
  typedef enum logic [1:0] {
    ACC_BYTE  = 2'd0,
    ACC_HALF  = 2'd1,
    ACC_WORD  = 2'd2,
    ACC_DWORD = 2'd3
  } accSizeT;

  // Core side request, valid is a one-cycle strobe
  typedef struct packed {
    logic              valid;
    logic              write;
    accSizeT           size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } accReqT;

  // Core side response
  typedef struct packed {
    logic              done;
    logic [DATA_W-1:0] rdata;   // Zero-extended lane
  } accRspT;

  // Word request toward the shared memory
  typedef struct packed {
    logic               valid;
    logic               write;
    logic [WORD_AW-1:0] wordAddr;
    logic [DATA_W-1:0]  wdata;
    logic [LANES-1:0]   byteMask;
  } memReqT;

endpackage

/* src/ctrlPkg.sv */
package ctrlPkg;

  localparam int NUM_CORES = 2;
  localparam int CORE_ID_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

  // Flag command opcodes
  typedef enum logic [2:0] {
    OP_FORCE_TILE   = 3'd0,
    OP_RELEASE_TILE = 3'd1,
    OP_FORCE_CORE   = 3'd2,
    OP_RELEASE_CORE = 3'd3,
    OP_GET_STATUS   = 3'd4
  } flagOpT;

  // One flag command, valid is a one-cycle strobe
  typedef struct packed {
    logic                 valid;
    flagOpT               op;
    logic [CORE_ID_W-1:0] coreId;
  } flagCmdT;

  // Status pattern returned for GET_STATUS
  typedef struct packed {
    logic tileReset;
    logic coreReset;
    logic failed;
    logic passed;
  } coreStatT;

endpackage

/* src/laneAccess.sv */
`timescale 1ns/1ps

module laneAccess
  import busPkg::*;
#(
  parameter int CORE_ID = 0
) (
  input  logic              dvtFlags,
  input  logic              pcFail,
  input  accReqT            req,
  output accRspT            rsp,
  output memReqT            memReq,
  input  logic              grant,
  input  logic [DATA_W-1:0] memRdata
);

  accReqT              pendReq;    // Request held until granted
  logic                pending;
  logic                doneQ;
  logic [LANE_W-1:0]   laneSel;    // Aligned byte offset
  logic [LANES-1:0]    laneMask;
  logic [DATA_W-1:0]   wdataRep;
  logic [DATA_W-1:0]   rdShift;

  // --------------------------------------------------------------------------
  // Pending and done tracking
  // --------------------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      pending <= 1'b0;
      doneQ   <= 1'b0;
    end else begin
      doneQ <= pending & grant;        // Memory answers one cycle after grant
      if (pending && grant) begin
        pending <= 1'b0;
      end else if (req.valid && !pending) begin
        pending <= 1'b1;               // Strobe while busy is dropped
      end
    end
  end

  // Payload capture, kept after grant so the read lane is still known
  always_ff @(posedge dvtFlags) begin
    if (req.valid && !pending) begin
      pendReq <= req;
    end
  end

  // --------------------------------------------------------------------------
  // Lane selection, mask and write replication
  // --------------------------------------------------------------------------
  always_comb begin
    case (pendReq.size)
      ACC_BYTE: begin
        laneSel  = pendReq.addr[2:0];
        laneMask = 8'h01 << pendReq.addr[2:0];
        wdataRep = {8{pendReq.wdata[7:0]}};
      end
      ACC_HALF: begin
        laneSel  = {pendReq.addr[2:1], 1'b0};
        laneMask = 8'h03 << {pendReq.addr[2:1], 1'b0};
        wdataRep = {4{pendReq.wdata[15:0]}};
      end
      ACC_WORD: begin
        laneSel  = {pendReq.addr[2], 2'b00};
        laneMask = pendReq.addr[2] ? 8'hF0 : 8'h0F;
        wdataRep = {2{pendReq.wdata[31:0]}};
      end
      default: begin
        laneSel  = '0;
        laneMask = '1;
        wdataRep = pendReq.wdata;
      end
    endcase
  end

  always_comb begin
    memReq.valid    = pending;
    memReq.write    = pendReq.write;
    memReq.wordAddr = pendReq.addr[ADDR_W-1:LANE_W];
    memReq.wdata    = wdataRep;
    memReq.byteMask = laneMask;
  end

  // Read lane moved down to bit 0, then zero-extended by size
  assign rdShift = memRdata >> {laneSel, 3'b000};

  always_comb begin
    rsp.done = doneQ;
    case (pendReq.size)
      ACC_BYTE:  rsp.rdata = {{(DATA_W-8){1'b0}}, rdShift[7:0]};
      ACC_HALF:  rsp.rdata = {{(DATA_W-16){1'b0}}, rdShift[15:0]};
      ACC_WORD:  rsp.rdata = {{(DATA_W-32){1'b0}}, rdShift[31:0]};
      default:   rsp.rdata = rdShift;
    endcase
  end

endmodule

/* src/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
  import busPkg::*;
(
  input  logic   dvtFlags,
  input  logic   pcFail,
  input  memReqT memReq0,
  input  memReqT memReq1,
  output logic   grant0,
  output logic   grant1,
  output memReqT memOut
);

  logic prio1;   // Set when engine 1 goes first on a tie

  // --------------------------------------------------------------------------
  // Combinational round-robin grant
  // --------------------------------------------------------------------------
  always_comb begin
    grant0 = memReq0.valid && (!memReq1.valid || !prio1);
    grant1 = memReq1.valid && (!memReq0.valid || prio1);
  end

  // Loser of the last grant takes priority next time
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      prio1 <= 1'b0;
    end else if (grant0) begin
      prio1 <= 1'b1;
    end else if (grant1) begin
      prio1 <= 1'b0;
    end
  end

  // Forward the winner
  always_comb begin
    if (grant1) begin
      memOut = memReq1;
    end else begin
      memOut = memReq0;      // Invalid when nobody asks
    end
  end

endmodule

/* src/sharedMemory.sv */
`timescale 1ns/1ps

module sharedMemory
  import busPkg::*;
#(
  parameter int MEM_WORDS = 64
) (
  input  logic              dvtFlags,
  input  memReqT            memReq,
  output logic [DATA_W-1:0] rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  idx;

  assign idx = memReq.wordAddr[IDX_W-1:0];   // Upper word bits alias

  always_ff @(posedge dvtFlags) begin
    if (memReq.valid) begin
      if (memReq.write) begin
        for (int i = 0; i < LANES; i++) begin
          if (memReq.byteMask[i]) begin
            mem[idx][8*i +: 8] <= memReq.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata <= mem[idx];                   // One-cycle read
      end
    end
  end

endmodule

/* src/resetControl.sv */
`timescale 1ns/1ps

module resetControl
  import ctrlPkg::*;
#(
  parameter int SLEEP_DELAY = 20
) (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  flagCmdT              flagCmd,
  input  logic [NUM_CORES-1:0] passed,
  input  logic [NUM_CORES-1:0] failed,
  output logic [NUM_CORES-1:0] tileReset,
  output logic [NUM_CORES-1:0] coreReset,
  output coreStatT             statusOut,
  output logic                 statusValid
);

  localparam int CNT_W = $clog2(SLEEP_DELAY + 1);

  logic [NUM_CORES-1:0] endSeen;     // Pass or fail reported
  logic [NUM_CORES-1:0] endSeenQ;
  logic [NUM_CORES-1:0] armed;       // Sleep timer running
  logic [CNT_W-1:0]     sleepCnt [NUM_CORES];

  assign endSeen = passed | failed;

  // --------------------------------------------------------------------------
  // Command decode and sleep timers
  // --------------------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileReset   <= '1;                 // Tiles start held
      coreReset   <= '0;
      statusValid <= 1'b0;
      endSeenQ    <= '0;
      armed       <= '0;
      for (int c = 0; c < NUM_CORES; c++) begin
        sleepCnt[c] <= '0;
      end
    end else begin
      statusValid <= 1'b0;
      if (flagCmd.valid) begin
        case (flagCmd.op)
          OP_FORCE_TILE:   tileReset[flagCmd.coreId] <= 1'b1;
          OP_RELEASE_TILE: tileReset[flagCmd.coreId] <= 1'b0;
          OP_FORCE_CORE:   coreReset[flagCmd.coreId] <= 1'b1;
          OP_RELEASE_CORE: coreReset[flagCmd.coreId] <= 1'b0;
          OP_GET_STATUS:   statusValid <= 1'b1;
          default: ;
        endcase
      end

      endSeenQ <= endSeen;
      for (int c = 0; c < NUM_CORES; c++) begin
        if (endSeen[c] && !endSeenQ[c]) begin
          armed[c]    <= 1'b1;
          sleepCnt[c] <= CNT_W'(SLEEP_DELAY - 1);
        end else if (armed[c]) begin
          if (sleepCnt[c] == CNT_W'(1)) begin
            armed[c]     <= 1'b0;
            coreReset[c] <= 1'b1;      // Put the core to sleep
          end else begin
            sleepCnt[c] <= sleepCnt[c] - 1'b1;
          end
        end
      end
    end
  end

  // Status pattern for the addressed core
  always_ff @(posedge dvtFlags) begin
    if (flagCmd.valid && flagCmd.op == OP_GET_STATUS) begin
      statusOut.tileReset <= tileReset[flagCmd.coreId];
      statusOut.coreReset <= coreReset[flagCmd.coreId];
      statusOut.failed    <= failed[flagCmd.coreId];
      statusOut.passed    <= passed[flagCmd.coreId];
    end
  end

endmodule

/* src/pcMonitor.sv */
`timescale 1ns/1ps

module pcMonitor
  import busPkg::*;
#(
  parameter logic [ADDR_W-1:0] PASS_ADDR   = 16'h0100,
  parameter logic [ADDR_W-1:0] FAIL_ADDR   = 16'h0104,
  parameter int                STUCK_LIMIT = 16
) (
  input  logic              dvtFlags,
  input  logic              pcFail,
  input  logic [ADDR_W-1:0] pc,
  input  logic              pcValid,
  output logic              passed,
  output logic              failed
);

  localparam int CNT_W = $clog2(STUCK_LIMIT + 1);

  logic [ADDR_W-1:0] lastPc;
  logic [CNT_W-1:0]  stuckCnt;   // Repeats of the same PC
  logic              samePc;
  logic              stuckHit;
  logic              passHit;
  logic              failHit;

  assign samePc   = (pc == lastPc);
  assign stuckHit = samePc && (stuckCnt >= CNT_W'(STUCK_LIMIT - 1));
  assign passHit  = (pc == PASS_ADDR);
  assign failHit  = (pc == FAIL_ADDR) || stuckHit;

  // --------------------------------------------------------------------------
  // Stuck counter and sticky pass or fail flags
  // --------------------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      lastPc   <= '0;
      stuckCnt <= '0;
      passed   <= 1'b0;
      failed   <= 1'b0;
    end else if (pcValid) begin
      lastPc <= pc;
      if (!samePc) begin
        stuckCnt <= '0;
      end else if (stuckCnt != CNT_W'(STUCK_LIMIT)) begin
        stuckCnt <= stuckCnt + 1'b1;      // Saturates at the limit
      end
      if (passHit) begin
        passed <= 1'b1;
      end
      if (failHit) begin
        failed <= 1'b1;
      end
    end
  end

endmodule

/* src/coreDriverTop.sv */
`timescale 1ns/1ps

module coreDriverTop
  import busPkg::*;
  import ctrlPkg::*;
#(
  parameter int                MEM_WORDS   = 64,
  parameter int                STUCK_LIMIT = 16,
  parameter logic [ADDR_W-1:0] PASS_ADDR   = 16'h0100,
  parameter logic [ADDR_W-1:0] FAIL_ADDR   = 16'h0104,
  parameter int                SLEEP_DELAY = 20
) (
  input  logic                 dvtFlags,
  input  logic                 pcFail,
  input  accReqT               accReq0,
  input  accReqT               accReq1,
  output accRspT               accRsp0,
  output accRspT               accRsp1,
  input  flagCmdT              flagCmd,
  input  logic [ADDR_W-1:0]    pc0,
  input  logic                 pcValid0,
  input  logic [ADDR_W-1:0]    pc1,
  input  logic                 pcValid1,
  output logic [NUM_CORES-1:0] tileReset,
  output logic [NUM_CORES-1:0] coreReset,
  output coreStatT             statusOut,
  output logic                 statusValid
);

  memReqT               memReq0;
  memReqT               memReq1;
  memReqT               memOut;
  logic                 grant0;
  logic                 grant1;
  logic [DATA_W-1:0]    memRdata;   // Shared by both engines
  logic [NUM_CORES-1:0] passed;
  logic [NUM_CORES-1:0] failed;

  // --------------------------------------------------------------------------
  // Memory access path
  // --------------------------------------------------------------------------
  laneAccess #(.CORE_ID(0)) uAccess0 (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .req(accReq0), .rsp(accRsp0),
    .memReq(memReq0), .grant(grant0), .memRdata(memRdata)
  );

  laneAccess #(.CORE_ID(1)) uAccess1 (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .req(accReq1), .rsp(accRsp1),
    .memReq(memReq1), .grant(grant1), .memRdata(memRdata)
  );

  busArbiter uArbiter (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .memReq0(memReq0), .memReq1(memReq1),
    .grant0(grant0), .grant1(grant1), .memOut(memOut)
  );

  sharedMemory #(.MEM_WORDS(MEM_WORDS)) uMemory (
    .dvtFlags(dvtFlags), .memReq(memOut), .rdata(memRdata)
  );

  // --------------------------------------------------------------------------
  // Reset control and PC monitors
  // --------------------------------------------------------------------------
  resetControl #(.SLEEP_DELAY(SLEEP_DELAY)) uResetCtl (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .flagCmd(flagCmd),
    .passed(passed), .failed(failed), .tileReset(tileReset), .coreReset(coreReset),
    .statusOut(statusOut), .statusValid(statusValid)
  );

  pcMonitor #(
    .PASS_ADDR(PASS_ADDR), .FAIL_ADDR(FAIL_ADDR), .STUCK_LIMIT(STUCK_LIMIT)
  ) uMonitor0 (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .pc(pc0), .pcValid(pcValid0),
    .passed(passed[0]), .failed(failed[0])
  );

  pcMonitor #(
    .PASS_ADDR(PASS_ADDR), .FAIL_ADDR(FAIL_ADDR), .STUCK_LIMIT(STUCK_LIMIT)
  ) uMonitor1 (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .pc(pc1), .pcValid(pcValid1),
    .passed(passed[1]), .failed(failed[1])
  );

endmodule

/* tb/tbCoreDriver.sv */
`timescale 1ns/1ps

module tbCoreDriver
  import busPkg::*;
  import ctrlPkg::*;
();

  localparam int SLEEP_DELAY = 20;
  localparam int STUCK_LIMIT = 16;
  localparam int MON_CYCLES  = 2 * (STUCK_LIMIT + 1 + SLEEP_DELAY);   // Both monitor tests

  logic                 dvtFlags;
  logic                 pcFail;
  accReqT               accReq [2];
  accRspT               accRsp [2];
  flagCmdT              flagCmd;
  logic [ADDR_W-1:0]    pc [2];
  logic                 pcValid [2];
  logic [NUM_CORES-1:0] tileReset;
  logic [NUM_CORES-1:0] coreReset;
  coreStatT             statusOut;
  logic                 statusValid;

  int          cycleCount;
  int          cycleLimit;
  int          markCycle;      // Edge that sampled the last monitored PC
  logic [15:0] lfsrState;
  accReqT      pairReq [2];    // One queued request per port
  logic [63:0] pairExp [2];

  coreDriverTop #(.SLEEP_DELAY(SLEEP_DELAY), .STUCK_LIMIT(STUCK_LIMIT)) UUT (
    .dvtFlags(dvtFlags), .pcFail(pcFail), .accReq0(accReq[0]), .accReq1(accReq[1]),
    .accRsp0(accRsp[0]), .accRsp1(accRsp[1]), .flagCmd(flagCmd),
    .pc0(pc[0]), .pcValid0(pcValid[0]), .pc1(pc[1]), .pcValid1(pcValid[1]),
    .tileReset(tileReset), .coreReset(coreReset), .statusOut(statusOut),
    .statusValid(statusValid)
  );

  initial begin
    dvtFlags = 1'b0;
    forever #2 dvtFlags = ~dvtFlags;
  end

  always @(posedge dvtFlags) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout, the run did not finish within %0d cycles", cycleLimit);
      failRun();
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic failRun();
    $display("test failed");
    $fatal(1, "stopped at cycle %0d", cycleCount);
  endtask

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic accReqT makeReq(input logic wr, input int size,
                                     input logic [63:0] addr, input logic [63:0] data);
    accReqT r;
    r.valid = 1'b1;
    r.write = wr;
    r.size  = accSizeT'(size[1:0]);
    r.addr  = addr[ADDR_W-1:0];
    r.wdata = data;
    return r;
  endfunction

  // Issue the queued requests of the ports in useMask, port 1 one cycle late if asked
  task automatic runAccesses(input logic [1:0] useMask, input logic late);
    logic [1:0] got;
    @(negedge dvtFlags);
    if (useMask[0]) accReq[0] = pairReq[0];
    if (useMask[1] && !late) accReq[1] = pairReq[1];
    @(negedge dvtFlags);
    accReq[0].valid = 1'b0;
    accReq[1].valid = 1'b0;
    if (useMask[1] && late) accReq[1] = pairReq[1];
    got = ~useMask;
    while (got != 2'b11) begin
      @(negedge dvtFlags);
      accReq[1].valid = 1'b0;
      for (int p = 0; p < 2; p++) begin
        if (accRsp[p].done) begin
          assert (!got[p]) else begin
            $display("port %0d returned done without an open access", p);
            failRun();
          end
          got[p] = 1'b1;
          if (!pairReq[p].write) begin
            assert (accRsp[p].rdata == pairExp[p]) else begin
              $display("ERR accRsp%0d.rdata exp %h got %h", p, pairExp[p], accRsp[p].rdata);
              failRun();
            end
          end
        end
      end
    end
  endtask

  task automatic sendFlag(input int core, input flagOpT op);
    @(negedge dvtFlags);
    flagCmd.valid  = 1'b1;
    flagCmd.op     = op;
    flagCmd.coreId = CORE_ID_W'(core);
    @(negedge dvtFlags);
    flagCmd.valid = 1'b0;
  endtask

  // Status comes back exactly one cycle after the command
  task automatic checkStatus(input int core, input logic [63:0] exp);
    sendFlag(core, OP_GET_STATUS);
    assert (statusValid) else begin
      $display("statusValid did not pulse after GET_STATUS for core %0d", core);
      failRun();
    end
    assert (statusOut == exp[3:0]) else begin
      $display("ERR statusOut exp %h got %h", exp[3:0], statusOut);
      failRun();
    end
  endtask

  task automatic runPc(input int core, input logic [63:0] addr, input int count);
    repeat (count) begin
      @(negedge dvtFlags);
      pc[core]      = addr[ADDR_W-1:0];
      pcValid[core] = 1'b1;
    end
    @(negedge dvtFlags);
    pcValid[core] = 1'b0;
    markCycle = cycleCount;
  endtask

  task automatic waitSleep(input int core, input logic [63:0] exp);
    while (!coreReset[core]) @(negedge dvtFlags);
    assert (cycleCount - markCycle == int'(exp)) else begin
      $display("ERR coreReset[%0d] delay exp %h got %h", core, exp[31:0],
               cycleCount - markCycle);
      failRun();
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int          fd;
    int          n;
    int          port;
    int          size;
    string       line;
    string       lines[$];
    logic [7:0]  op;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] exp;
    pcFail     = 1'b1;
    cycleCount = 0;
    cycleLimit = 0;
    markCycle  = 0;
    lfsrState  = 16'd39621;
    flagCmd    = '0;
    for (int p = 0; p < 2; p++) begin
      accReq[p]  = '0;
      pc[p]      = '0;
      pcValid[p] = 1'b0;
    end
    fd = $fopen("tb/testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/testdata.txt");
      failRun();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
    end
    $fclose(fd);
    cycleLimit = lines.size() * 40 + MON_CYCLES;
    repeat (4) @(negedge dvtFlags);
    pcFail = 1'b0;

    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%c %d %d %h %h %h", op, port, size, addr, data, exp);
      if (n != 6) begin
        $display("malformed line in the data file: %s", lines[i]);
        failRun();
      end
      case (op)
        "W", "R": begin
          pairReq[port] = makeReq(op == "W", size, addr, data);
          pairExp[port] = exp;
          runAccesses((port == 0) ? 2'b01 : 2'b10, 1'b0);
        end
        "w", "r": begin                      // Held until the next G
          pairReq[port] = makeReq(op == "w", size, addr, data);
          pairExp[port] = exp;
        end
        "G": begin
          lfsrState = lfsrNext(lfsrState);
          runAccesses(2'b11, lfsrState[0]);
        end
        "F": sendFlag(port, flagOpT'(size[2:0]));
        "S": checkStatus(port, exp);
        "T": begin
          assert ({coreReset, tileReset} == exp[3:0]) else begin
            $display("ERR {coreReset,tileReset} exp %h got %h", exp[3:0],
                     {coreReset, tileReset});
            failRun();
          end
        end
        "M": runPc(port, addr, int'(data));
        "Z": waitSleep(port, exp);
        default: begin
          $display("unknown operation in the data file: %s", lines[i]);
          failRun();
        end
      endcase
    end
    $display("test passed");
    $finish;
  end

endmodule

/* tb/testdata.txt */
# op port size addr data expect, port and size decimal, the rest hex
# W R access, w r queue a pair side, G run pair, F flag op=size, S status, T resets, M pc, Z sleep
T 0 0 0 0 3
W 0 3 0008 1122334455667788 0
R 1 0 000B 0 55
R 0 1 000C 0 3344
R 1 2 000C 0 11223344
W 1 1 000A ABCD 0
R 0 3 0008 0 11223344ABCD7788
W 0 0 0018 11 0
W 1 0 0019 22 0
W 0 0 001A 33 0
W 1 0 001B 44 0
W 0 0 001C 55 0
W 1 0 001D 66 0
W 0 0 001E 77 0
W 1 0 001F 88 0
R 0 3 0018 0 8877665544332211
w 0 3 0040 0102030405060708 0
w 1 3 0080 A0B0C0D0E0F01020 0
G 0 0 0 0 0
r 0 3 0080 0 A0B0C0D0E0F01020
r 1 2 0044 0 01020304
G 0 0 0 0 0
F 0 1 0 0 0
F 1 2 0 0 0
T 0 0 0 0 A
S 1 0 0 0 C
F 1 3 0 0 0
M 0 0 0100 1 0
S 0 0 0 0 1
Z 0 0 0 0 14
M 1 0 0200 11 0
S 1 0 0 0 A
Z 1 0 0 0 14
T 0 0 0 0 E

/* flist.f */
src/busPkg.sv
src/ctrlPkg.sv
src/laneAccess.sv
src/busArbiter.sv
src/sharedMemory.sv
src/resetControl.sv
src/pcMonitor.sv
src/coreDriverTop.sv
tb/tbCoreDriver.sv

/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing
TOP     = tbCoreDriver
RTL_TOP = coreDriverTop
FLIST   = flist.f
MDIR    = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

run: build
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(MDIR) $(LOG)
